//--- list.f
src/sensorPkg.sv
src/capturePkg.sv
src/pixelIf.sv
src/frameSequencer.sv
src/timeBase.sv
src/hitFifo.sv
src/hitRecorder.sv
src/sensorCapture.sv
tests/tbSensorCapture.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tbSensorCapture -f list.f -o simv
	-./obj_dir/simv > sim.log 2>&1
	@cat sim.log
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/tbSensorCapture.sv
module tbSensorCapture;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int frameCycles = (sensorPkg::linesPerFrame * sensorPkg::pixelsPerLine +
		sensorPkg::tailPixels) * sensorPkg::phasesPerPixel; // busy cycles of one frame
	localparam int adcHighCycles = sensorPkg::adcClockLastPhase -
		sensorPkg::adcClockFirstPhase + 1;
	localparam int syncCycles = sensorPkg::frameSyncPixels * sensorPkg::phasesPerPixel;
	localparam int windowPixels = (sensorPkg::activeColLast - sensorPkg::activeColFirst + 1) *
		(sensorPkg::activeRowLast - sensorPkg::activeRowFirst + 1);
	localparam int waitLimit = frameCycles + 200; // cycles before any wait gives up

	logic bls0we;
	logic resadd = 1'b1;
	logic start = 1'b0;
	capturePkg::thresholdT threshold = '0;
	sensorPkg::adcT adcData = '0;
	logic hitRead = 1'b0;
	logic busy;
	logic frameDone;
	logic sensorClock;
	logic frameSync;
	logic lineSync;
	logic adcClock;
	capturePkg::hitT hitData;
	logic hitEmpty;
	logic overflow;

	integer seed = 32'hcba6_0321; // adc model stream
	int cycle = 0; // rising edges so far
	int startCycle = 0; // cycle count seen just after the last start was taken
	int col = 0; // column of the running conversion
	int row = 0;
	int lineRises;
	int adcPulses;
	int syncPulses;
	int busyCycles;
	int framesDone;
	int pops;
	int clockToggles; // sensor clock edges of the running frame
	int adcHighLen = 0;
	int syncHighLen = 0;
	logic lineSyncPrev = 1'b0;
	logic adcClockPrev = 1'b0;
	logic frameSyncPrev = 1'b0;
	logic busyPrev = 1'b0;
	logic sensorClockPrev = 1'b0;
	logic readEnable = 1'b0; // host pops whenever the fifo has data
	int lastGotStamp;
	int lastWantStamp;
	capturePkg::hitT expected[$]; // hits in the order they must come out

	sensorCapture u_sensorCapture (
		.bls0we (bls0we),
		.resadd (resadd),
		.start (start),
		.threshold (threshold),
		.adcData (adcData),
		.hitRead (hitRead),
		.busy (busy),
		.frameDone (frameDone),
		.sensorClock (sensorClock),
		.frameSync (frameSync),
		.lineSync (lineSync),
		.adcClock (adcClock),
		.hitData (hitData),
		.hitEmpty (hitEmpty),
		.overflow (overflow)
	);

	initial begin
		bls0we = 1'b0;
		forever #5 bls0we = ~bls0we;
	end

	task automatic stopRun();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic failWith(input string msg);
		$display("%s (at %0t ns)", msg, $time);
		stopRun();
	endtask

	task automatic valueError(input string name, input int got, input int want);
		$display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, want);
		stopRun();
	endtask

	task automatic checkValue(input string name, input int got, input int want);
		assert (got == want) else valueError(name, got, want);
	endtask

	// conversions only happen inside a frame
	adcInFrame: assert property (@(posedge bls0we) disable iff (resadd) adcClock |-> busy)
		else failWith("adcClock pulsed while no frame was running");
	// frameDone lasts one cycle
	doneSingle: assert property (@(posedge bls0we) disable iff (resadd)
		frameDone |-> !$past(frameDone))
		else failWith("frameDone stayed high for more than one cycle");

	always @(posedge bls0we) begin
		if (start) begin
			startCycle <= cycle + 1; // time base restarts on any start
		end
		cycle <= cycle + 1;
	end

	// sensor and adc model that samples the outputs 1 ns after the edge
	always @(posedge bls0we) begin
		logic [9:0] brightness;
		capturePkg::hitT entry;
		#1;
		if (lineSync && !lineSyncPrev) begin
			row = frameSync ? 0 : row + 1; // frame sync marks line 0
			col = 0;
			lineRises++;
		end
		if (frameSync && !frameSyncPrev) begin
			syncPulses++;
		end
		if (frameSync) begin
			syncHighLen++;
		end else if (frameSyncPrev) begin
			checkValue("frameSync width", syncHighLen, syncCycles);
			syncHighLen = 0;
		end
		if (adcClock && !adcClockPrev) begin
			adcData = sensorPkg::adcT'($random(seed)); // new conversion result
			adcPulses++;
			brightness = ~adcData[11:2]; // bright pixels give low codes
			if (col >= sensorPkg::activeColFirst && col <= sensorPkg::activeColLast &&
				row >= sensorPkg::activeRowFirst && row <= sensorPkg::activeRowLast &&
				brightness >= threshold) begin
				entry.col = sensorPkg::colT'(col);
				entry.row = sensorPkg::rowT'(row);
				entry.stamp = capturePkg::stampT'((cycle - startCycle) / capturePkg::tickCycles);
				expected.push_back(entry);
			end
			col++;
		end
		if (adcClock) begin
			adcHighLen++;
		end else if (adcClockPrev) begin
			checkValue("adcClock width", adcHighLen, adcHighCycles);
			adcHighLen = 0;
			adcData = ~adcData; // junk once the conversion is over
		end
		if (busy) begin
			busyCycles++;
		end
		if (sensorClock != sensorClockPrev) begin
			clockToggles++;
		end
		if (frameDone) begin
			checkValue("busy at frameDone", busy, 0);
			checkValue("busy before frameDone", busyPrev, 1);
			framesDone++;
		end
		lineSyncPrev = lineSync;
		adcClockPrev = adcClock;
		frameSyncPrev = frameSync;
		busyPrev = busy;
		sensorClockPrev = sensorClock;
	end

	task automatic checkRecord(input capturePkg::hitT got);
		capturePkg::hitT want;
		int diff;
		if (expected.size() == 0) begin
			failWith("a record was popped while no hit was expected");
		end else begin
			want = expected.pop_front();
			assert (got.col >= sensorPkg::activeColFirst && got.col <= sensorPkg::activeColLast &&
				got.row >= sensorPkg::activeRowFirst && got.row <= sensorPkg::activeRowLast)
				else failWith("popped record lies outside the active window");
			checkValue("hitData.col", got.col, want.col);
			checkValue("hitData.row", got.row, want.row);
			if (int'(want.stamp) < lastWantStamp) begin
				lastGotStamp = 0; // a start cleared the time base in between
			end
			lastWantStamp = want.stamp;
			assert (int'(got.stamp) >= lastGotStamp)
				else failWith("hit stamp went backwards within a frame");
			lastGotStamp = got.stamp;
			diff = int'(got.stamp) - int'(want.stamp); // strobe lags the adc edge by a few cycles
			assert (diff >= 0 && diff <= 1) else valueError("hitData.stamp", got.stamp, want.stamp);
		end
	endtask

	// host pops one record per cycle
	always @(posedge bls0we) begin
		#1;
		hitRead = 1'b0;
		if (readEnable && !hitEmpty) begin
			checkRecord(hitData);
			hitRead = 1'b1;
			pops++;
		end
	end

	task automatic clearCounts();
		lineRises = 0;
		adcPulses = 0;
		syncPulses = 0;
		busyCycles = 0;
		framesDone = 0;
		pops = 0;
		clockToggles = 0;
		lastGotStamp = 0;
		lastWantStamp = 0;
	endtask

	task automatic pulseStart();
		@(posedge bls0we);
		#1 start = 1'b1;
		@(posedge bls0we);
		#1 start = 1'b0;
	endtask

	task automatic setThreshold(input capturePkg::thresholdT value);
		@(posedge bls0we);
		#1 threshold = value;
	endtask

	task automatic waitFrameDone();
		int n;
		n = 0;
		@(negedge bls0we);
		while (!frameDone && n < waitLimit) begin
			@(negedge bls0we);
			n++;
		end
		if (!frameDone) failWith("timeout while waiting for frameDone");
	endtask

	task automatic waitLines(input int count);
		int n;
		n = 0;
		while (lineRises < count && n < waitLimit) begin
			@(negedge bls0we);
			n++;
		end
		if (lineRises < count) failWith("timeout while waiting for lineSync");
	endtask

	task automatic waitDrained();
		int n;
		n = 0;
		@(negedge bls0we);
		while (!(hitEmpty && !hitRead) && n < 100) begin
			@(negedge bls0we);
			n++;
		end
		if (!hitEmpty || hitRead) failWith("timeout while draining the hit fifo");
	endtask

	task automatic checkFrame();
		checkValue("frameDone pulses", framesDone, 1);
		checkValue("frameSync pulses", syncPulses, 1);
		checkValue("lineSync pulses", lineRises, sensorPkg::linesPerFrame);
		checkValue("adcClock pulses", adcPulses,
			sensorPkg::linesPerFrame * sensorPkg::pixelsPerLine);
		checkValue("busy cycles", busyCycles, frameCycles);
		checkValue("sensorClock toggles", clockToggles,
			sensorPkg::linesPerFrame * sensorPkg::pixelsPerLine + sensorPkg::tailPixels);
		checkValue("sensorClock", sensorClock, 0);
	endtask

	task automatic runReadFrame(input capturePkg::thresholdT value);
		setThreshold(value);
		clearCounts();
		readEnable = 1'b1;
		pulseStart();
		@(negedge bls0we);
		checkValue("busy", busy, 1);
		checkValue("overflow", overflow, 0); // start clears it
		waitFrameDone();
		checkFrame();
		waitDrained();
		checkValue("hits not popped", expected.size(), 0);
		checkValue("overflow", overflow, 0);
	endtask

	initial begin
		repeat (10) @(posedge bls0we);
		#1 resadd = 1'b0;
		@(negedge bls0we);
		checkValue("busy", busy, 0);
		checkValue("frameDone", frameDone, 0);
		checkValue("frameSync", frameSync, 0);
		checkValue("lineSync", lineSync, 0);
		checkValue("adcClock", adcClock, 0);
		checkValue("sensorClock", sensorClock, 0);
		checkValue("overflow", overflow, 0);
		checkValue("hitEmpty", hitEmpty, 1);

		runReadFrame('0); // every window pixel is a hit

		// only the brightest code hits and a second start lands mid frame
		setThreshold('1);
		clearCounts();
		pulseStart();
		waitLines(3);
		pulseStart();
		waitFrameDone();
		checkFrame();
		waitDrained();
		checkValue("hits not popped", expected.size(), 0);

		// without reads the fifo fills and drops the rest
		setThreshold('0);
		clearCounts();
		readEnable = 1'b0;
		pulseStart();
		waitFrameDone();
		checkFrame();
		checkValue("overflow", overflow, 1);
		checkValue("expected hits", expected.size(), windowPixels);
		readEnable = 1'b1;
		waitDrained();
		checkValue("records popped", pops, capturePkg::fifoDepth);
		checkValue("hitEmpty", hitEmpty, 1);
		expected.delete(); // the dropped ones never come out

		runReadFrame(10'd512);

		$display("Test OK");
		$finish;
	end

endmodule

//--- src/sensorCapture.sv
module sensorCapture (
	input logic bls0we,
	input logic resadd,
	input logic start,
	input capturePkg::thresholdT threshold,
	input sensorPkg::adcT adcData,
	input logic hitRead,
	output logic busy,
	output logic frameDone,
	output logic sensorClock,
	output logic frameSync,
	output logic lineSync,
	output logic adcClock,
	output capturePkg::hitT hitData,
	output logic hitEmpty,
	output logic overflow
);

	pixelIf pix (); // sequencer to recorder

	capturePkg::stampT stamp; // current coarse time
	capturePkg::hitT hit; // record on its way to the fifo
	logic hitWrite;
	logic fifoFull;

	frameSequencer u_frameSequencer (
		.bls0we (bls0we),
		.resadd (resadd),
		.start (start),
		.busy (busy),
		.frameDone (frameDone),
		.sensorClock (sensorClock),
		.frameSync (frameSync),
		.lineSync (lineSync),
		.adcClock (adcClock),
		.adcData (adcData),
		.pix (pix.seq)
	);

	timeBase u_timeBase (
		.bls0we (bls0we),
		.resadd (resadd),
		.start (start),
		.stamp (stamp)
	);

	hitRecorder u_hitRecorder (
		.bls0we (bls0we),
		.resadd (resadd),
		.start (start),
		.pix (pix.rec),
		.stamp (stamp),
		.threshold (threshold),
		.fifoFull (fifoFull),
		.hitWrite (hitWrite),
		.hit (hit),
		.overflow (overflow)
	);

	hitFifo u_hitFifo (
		.bls0we (bls0we),
		.resadd (resadd),
		.write (hitWrite),
		.data (hit),
		.read (hitRead),
		.head (hitData),
		.full (fifoFull),
		.empty (hitEmpty)
	);

endmodule

//--- src/hitRecorder.sv
module hitRecorder (
	input logic bls0we,
	input logic resadd,
	input logic start,
	pixelIf.rec pix,
	input capturePkg::stampT stamp,
	input capturePkg::thresholdT threshold,
	input logic fifoFull,
	output logic hitWrite,
	output capturePkg::hitT hit,
	output logic overflow
);

	logic [9:0] brightness; // sensor output falls with light, so invert
	logic colInside;
	logic rowInside;
	logic isHit;

	assign brightness = ~pix.sample[11:2];
	assign colInside = (pix.col >= sensorPkg::colT'(sensorPkg::activeColFirst)) &&
		(pix.col <= sensorPkg::colT'(sensorPkg::activeColLast));
	assign rowInside = (pix.row >= sensorPkg::rowT'(sensorPkg::activeRowFirst)) &&
		(pix.row <= sensorPkg::rowT'(sensorPkg::activeRowLast));
	assign isHit = pix.pixelValid && colInside && rowInside && (brightness >= threshold);

	// one stage, a new pixel may enter while the last record goes out
	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			hitWrite <= 1'b0;
		end else begin
			hitWrite <= isHit;
		end
	end

	always_ff @(posedge bls0we) begin
		if (isHit) begin
			hit.col <= pix.col;
			hit.row <= pix.row;
			hit.stamp <= stamp; // time of the pixel strobe
		end
	end

	// sticky until the next frame start
	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			overflow <= 1'b0;
		end else if (start) begin
			overflow <= 1'b0;
		end else if (hitWrite && fifoFull) begin
			overflow <= 1'b1; // record lost at the fifo
		end
	end

endmodule

//--- src/hitFifo.sv
module hitFifo (
	input logic bls0we,
	input logic resadd,
	input logic write,
	input capturePkg::hitT data,
	input logic read,
	output capturePkg::hitT head,
	output logic full,
	output logic empty
);

	capturePkg::hitT mem [capturePkg::fifoDepth]; // record storage
	capturePkg::fifoPtrT wrPtr; // next slot to fill
	capturePkg::fifoPtrT rdPtr; // oldest record
	capturePkg::fifoCountT count; // records held

	logic doWrite;
	logic doRead;

	assign full = count == capturePkg::fifoCountT'(capturePkg::fifoDepth);
	assign empty = count == '0;
	assign doWrite = write && !full; // full fifo drops the record
	assign doRead = read && !empty; // pop on empty is a no-op
	assign head = mem[rdPtr]; // show-ahead, no read latency

	function automatic capturePkg::fifoPtrT nextPtr(input capturePkg::fifoPtrT ptr);
		if (ptr == capturePkg::fifoPtrT'(capturePkg::fifoDepth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge bls0we) begin
		if (doWrite) begin
			mem[wrPtr] <= data;
		end
	end

	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (doRead) begin
				rdPtr <= nextPtr(rdPtr);
			end
			if (doWrite && !doRead) begin
				count <= count + 1'b1;
			end else if (doRead && !doWrite) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

//--- src/timeBase.sv
module timeBase (
	input logic bls0we,
	input logic resadd,
	input logic start,
	output capturePkg::stampT stamp
);

	localparam int divBits = $clog2(capturePkg::tickCycles);

	logic [divBits - 1:0] divider; // cycles inside the current tick
	logic tick;

	assign tick = divider == divBits'(capturePkg::tickCycles - 1);

	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			divider <= '0;
		end else if (start) begin
			divider <= '0; // restart the tick phase with the frame
		end else if (tick) begin
			divider <= '0;
		end else begin
			divider <= divider + 1'b1;
		end
	end

	// free running, does not care about frame state
	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			stamp <= '0;
		end else if (start) begin
			stamp <= '0; // zero on the cycle after start
		end else if (tick) begin
			if (stamp == capturePkg::stampT'(capturePkg::stampModulus - 1)) begin
				stamp <= '0; // wrap
			end else begin
				stamp <= stamp + 1'b1;
			end
		end
	end

endmodule

//--- src/frameSequencer.sv
module frameSequencer (
	input logic bls0we,
	input logic resadd,
	input logic start,
	output logic busy,
	output logic frameDone,
	output logic sensorClock,
	output logic frameSync,
	output logic lineSync,
	output logic adcClock,
	input sensorPkg::adcT adcData,
	pixelIf.seq pix
);

	sensorPkg::seqStateT state; // idle / run / tail
	sensorPkg::phaseT phase; // cycle inside the pixel period
	sensorPkg::colT pixel; // pixel period inside the line, or inside the tail
	sensorPkg::rowT line; // current line

	logic lastPhase;
	logic lastPixel;
	logic lastLine;
	logic frameEnd;
	logic sampleNow;

	assign lastPhase = phase == sensorPkg::phaseT'(sensorPkg::phasesPerPixel - 1);
	assign lastPixel = pixel == sensorPkg::colT'(sensorPkg::pixelsPerLine - 1);
	assign lastLine = line == sensorPkg::rowT'(sensorPkg::linesPerFrame - 1);
	assign frameEnd = (state == sensorPkg::seqTail) && lastPhase &&
		(pixel == sensorPkg::colT'(sensorPkg::tailPixels - 1)); // last cycle of the tail
	assign sampleNow = (state == sensorPkg::seqRun) &&
		(phase == sensorPkg::phaseT'(sensorPkg::samplePhase)); // adc word valid here

	assign busy = state != sensorPkg::seqIdle; // state is registered, so busy follows start by one
	assign frameSync = (state == sensorPkg::seqRun) && (line == '0) &&
		(pixel < sensorPkg::colT'(sensorPkg::frameSyncPixels)); // first pixels of the frame
	assign lineSync = (state == sensorPkg::seqRun) && (pixel == '0); // pixel period 0 of each line
	assign adcClock = (state == sensorPkg::seqRun) &&
		(phase >= sensorPkg::phaseT'(sensorPkg::adcClockFirstPhase)) &&
		(phase <= sensorPkg::phaseT'(sensorPkg::adcClockLastPhase)); // no conversions in the tail

	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			state <= sensorPkg::seqIdle;
			phase <= '0;
			pixel <= '0;
			line <= '0;
			sensorClock <= 1'b0;
			frameDone <= 1'b0;
		end else begin
			frameDone <= 1'b0; // single cycle pulse
			case (state)
				sensorPkg::seqIdle: begin
					if (start) begin // start while busy never gets here
						state <= sensorPkg::seqRun;
						phase <= '0;
						pixel <= '0;
						line <= '0;
						sensorClock <= ~sensorClock; // first pixel period opens with a toggle
					end
				end
				default: begin
					if (!lastPhase) begin
						phase <= phase + 1'b1;
					end else if (frameEnd) begin
						phase <= '0;
						state <= sensorPkg::seqIdle; // even toggle count leaves sensorClock low
						frameDone <= 1'b1;
					end else begin
						phase <= '0;
						sensorClock <= ~sensorClock; // next pixel period starts at phase 0
						if (state == sensorPkg::seqTail) begin
							pixel <= pixel + 1'b1; // tail only counts pixel periods
						end else if (!lastPixel) begin
							pixel <= pixel + 1'b1;
						end else if (!lastLine) begin
							pixel <= '0;
							line <= line + 1'b1;
						end else begin
							pixel <= '0; // tail counts from 0
							state <= sensorPkg::seqTail;
						end
					end
				end
			endcase
		end
	end

	// strobe lags the sample phase by one, payload is stable with it
	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			pix.pixelValid <= 1'b0;
		end else begin
			pix.pixelValid <= sampleNow;
		end
	end

	always_ff @(posedge bls0we) begin
		if (sampleNow) begin
			pix.sample <= adcData; // adc holds its word while adcClock is high
			pix.col <= pixel;
			pix.row <= line;
		end
	end

endmodule

//--- src/pixelIf.sv
// latched pixel stream, one strobe per pixel period, no stall
interface pixelIf;

	logic pixelValid; // one cycle, the cycle after the sample phase
	sensorPkg::colT col; // column of the sample
	sensorPkg::rowT row; // row of the sample
	sensorPkg::adcT sample; // raw adc word

	modport seq (
		output pixelValid,
		output col,
		output row,
		output sample
	);

	modport rec (
		input pixelValid,
		input col,
		input row,
		input sample
	);

endinterface

//--- src/capturePkg.sv
package capturePkg;

	localparam int tickCycles = 20; // clock cycles per timestamp tick
	localparam int stampModulus = 1 << 20; // stamp wraps to 0 here

	typedef logic [19:0] stampT; // coarse timestamp
	typedef logic [9:0] thresholdT; // brightness threshold

	// one queued hit
	typedef struct packed {
		sensorPkg::colT col; // pixel column
		sensorPkg::rowT row; // pixel row
		stampT stamp; // time base value at the pixel strobe
	} hitT;

	localparam int fifoDepth = 8; // records held by the hit fifo

	typedef logic [$clog2(fifoDepth) - 1:0] fifoPtrT; // read / write pointer
	typedef logic [$clog2(fifoDepth + 1) - 1:0] fifoCountT; // fill level 0..depth

endpackage

//--- src/sensorPkg.sv
package sensorPkg;

	localparam int pixelsPerLine = 16; // pixel periods per line, blanking included
	localparam int linesPerFrame = 10; // lines per frame

	localparam int activeColFirst = 2; // active window columns, inclusive
	localparam int activeColLast = 13;
	localparam int activeRowFirst = 1; // active window rows, inclusive
	localparam int activeRowLast = 8;

	localparam int phasesPerPixel = 10; // clock cycles per pixel period
	localparam int adcClockFirstPhase = 2; // adc clock high from this phase
	localparam int adcClockLastPhase = 6; // up to and including this one
	localparam int samplePhase = 6; // sample latched here, last adc high phase

	localparam int frameSyncPixels = 3; // frame sync length in pixel periods
	localparam int tailPixels = 4; // idle pixel periods after the last line

	localparam int adcWidth = 13; // adc word width

	typedef logic [$clog2(pixelsPerLine + 1) - 1:0] colT; // column index
	typedef logic [$clog2(linesPerFrame + 1) - 1:0] rowT; // row index
	typedef logic [adcWidth - 1:0] adcT; // raw adc word
	typedef logic [$clog2(phasesPerPixel) - 1:0] phaseT; // phase inside a pixel period

	// sequencer runs the lines, then a short tail with the sensor clock only
	typedef enum logic [1:0] {
		seqIdle,
		seqRun,
		seqTail
	} seqStateT;

endpackage
